/* src/cache_pkg.sv */
`default_nettype none

package cache_pkg;

    // Access modes, same codes as load/store funct3
    localparam logic [2:0] mode_b  = 3'd0;
    localparam logic [2:0] mode_h  = 3'd1;
    localparam logic [2:0] mode_w  = 3'd2;
    localparam logic [2:0] mode_bu = 3'd4;
    localparam logic [2:0] mode_hu = 3'd5;

    localparam int addr_width = 32;
    localparam int data_width = 32;

    // Address split: tag | set | byte offset
    localparam int tag_width    = 26;
    localparam int set_width    = 4;
    localparam int offset_width = 2;

    localparam int num_sets = 16;

    // Backing store is indexed by address bits 11..2
    localparam int mem_words       = 1024;
    localparam int mem_index_width = $clog2(mem_words);

    // One address word, seen either as a flat word or as cache fields
    typedef union packed {
        logic [addr_width-1:0] raw;
        struct packed {
            logic [tag_width-1:0]    tag;
            logic [set_width-1:0]    set;
            logic [offset_width-1:0] offset;
        } fields;
    } cache_addr_u;

endpackage

`default_nettype wire

/* src/cache_way.sv */
`default_nettype none

module cache_way (
    input  logic                                clk,
    input  logic                                rst_n,
    input  cache_pkg::cache_addr_u              lookup_addr,
    input  logic                                fill,
    input  logic [cache_pkg::data_width-1:0]    fill_data,
    input  logic                                store,
    input  logic [3:0]                          be,
    input  logic [cache_pkg::data_width-1:0]    store_data,
    output logic                                valid,
    output logic                                hit,
    output logic [cache_pkg::data_width-1:0]    rdata
);

    logic [cache_pkg::num_sets-1:0]  valid_bits;
    logic [cache_pkg::tag_width-1:0] tag_ram [cache_pkg::num_sets];
    logic [cache_pkg::data_width-1:0] data_ram [cache_pkg::num_sets];
    logic [cache_pkg::set_width-1:0] set_idx;

    assign set_idx = lookup_addr.fields.set;

    // Combinational lookup of the addressed set
    assign valid = valid_bits[set_idx];
    assign hit   = valid && (tag_ram[set_idx] == lookup_addr.fields.tag);
    assign rdata = data_ram[set_idx];

    // A refill marks the set valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_bits <= '0;
        end else if (fill) begin
            valid_bits[set_idx] <= 1'b1;
        end
    end

    // Refill replaces tag and whole word while a store hit merges bytes
    always_ff @(posedge clk) begin
        if (fill) begin
            tag_ram[set_idx]  <= lookup_addr.fields.tag;
            data_ram[set_idx] <= fill_data;
        end else if (store && hit) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    data_ram[set_idx][8*b +: 8] <= store_data[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/cache_ctrl.sv */
`default_nettype none

module cache_ctrl (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                req,
    input  logic                                we,
    input  logic [2:0]                          mode,
    input  cache_pkg::cache_addr_u              addr,
    input  logic [cache_pkg::data_width-1:0]    wdata,
    input  logic                                hit0,
    input  logic                                hit1,
    input  logic [cache_pkg::data_width-1:0]    way0_data,
    input  logic [cache_pkg::data_width-1:0]    way1_data,
    input  logic                                valid0,
    input  logic                                valid1,
    input  logic [cache_pkg::data_width-1:0]    mem_rdata,
    output cache_pkg::cache_addr_u              lookup_addr,
    output logic                                fill0,
    output logic                                fill1,
    output logic                                store_out,
    output logic [3:0]                          be,
    output logic [cache_pkg::data_width-1:0]    store_data,
    output logic                                mem_re,
    output logic                                mem_we,
    output logic [cache_pkg::data_width-1:0]    rdata,
    output logic                                rvalid,
    output logic                                hit,
    output logic                                busy
);

    // Registered request
    logic                               req_q;
    logic                               we_q;
    logic [2:0]                         mode_q;
    cache_pkg::cache_addr_u             addr_q;
    logic [cache_pkg::data_width-1:0]   wdata_q;

    // Miss context, kept for the refill cycle
    logic                               in_refill;
    cache_pkg::cache_addr_u             miss_addr;
    logic [2:0]                         miss_mode;
    logic                               victim_q;

    // One bit per set, names the least recently used way
    logic [cache_pkg::num_sets-1:0]     lru;

    logic                               active;
    logic                               load_go;
    logic                               store_go;
    logic                               any_hit;
    logic                               victim;
    logic [cache_pkg::data_width-1:0]   hit_word;

    // Pick the addressed part of a word and extend it per mode
    function automatic logic [cache_pkg::data_width-1:0] load_extract(
        input logic [cache_pkg::data_width-1:0] word,
        input logic [1:0]                       offset,
        input logic [2:0]                       ld_mode
    );
        logic [cache_pkg::data_width-1:0] shifted;
        shifted = word >> {offset, 3'b000};
        case (ld_mode)
            cache_pkg::mode_b:  load_extract = {{24{shifted[7]}}, shifted[7:0]};
            cache_pkg::mode_bu: load_extract = {24'b0, shifted[7:0]};
            cache_pkg::mode_h:  load_extract = {{16{shifted[15]}}, shifted[15:0]};
            cache_pkg::mode_hu: load_extract = {16'b0, shifted[15:0]};
            default:            load_extract = word;
        endcase
    endfunction

    // Work happens only outside refill, a request captured then waits
    assign active   = req_q && !in_refill;
    assign load_go  = active && !we_q;
    assign store_go = active && we_q;

    assign any_hit  = hit0 || hit1;
    assign hit_word = hit1 ? way1_data : way0_data;

    // Invalid way first, way 0 before way 1, else LRU
    assign victim = !valid0 ? 1'b0 : (!valid1 ? 1'b1 : lru[addr_q.fields.set]);

    assign lookup_addr = in_refill ? miss_addr : addr_q;
    assign fill0       = in_refill && !victim_q;
    assign fill1       = in_refill && victim_q;

    // Write-through, every store goes to memory, ways update on hit only
    assign store_out = store_go;
    assign mem_we    = store_go;
    assign mem_re    = load_go;
    assign busy      = in_refill;

    // Store lane alignment
    always_comb begin
        case (mode_q)
            cache_pkg::mode_b, cache_pkg::mode_bu: begin
                be         = 4'b0001 << addr_q.fields.offset;
                store_data = {4{wdata_q[7:0]}};
            end
            cache_pkg::mode_h, cache_pkg::mode_hu: begin
                be         = addr_q.fields.offset[1] ? 4'b1100 : 4'b0011;
                store_data = {2{wdata_q[15:0]}};
            end
            cache_pkg::mode_w: begin
                be         = 4'b1111;
                store_data = wdata_q;
            end
            default: begin
                // Unknown mode writes nothing
                be         = 4'b0000;
                store_data = wdata_q;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q <= 1'b0;
        end else if (!in_refill) begin
            req_q <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (!in_refill && req) begin
            we_q    <= we;
            mode_q  <= mode;
            addr_q  <= addr;
            wdata_q <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (load_go && !any_hit) begin
            miss_addr <= addr_q;
            miss_mode <= mode_q;
            victim_q  <= victim;
        end
    end

    // Idle/refill sequence, result strobe and LRU upkeep
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_refill <= 1'b0;
            rvalid    <= 1'b0;
            lru       <= '0;
        end else begin
            rvalid <= 1'b0;
            if (in_refill) begin
                in_refill                 <= 1'b0;
                rvalid                    <= 1'b1;
                lru[miss_addr.fields.set] <= !victim_q;
            end else if (active && any_hit) begin
                lru[addr_q.fields.set] <= hit0;
                rvalid                 <= !we_q;
            end else if (load_go) begin
                in_refill <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_refill) begin
            rdata <= load_extract(mem_rdata, miss_addr.fields.offset, miss_mode);
            hit   <= 1'b0;
        end else if (load_go && any_hit) begin
            rdata <= load_extract(hit_word, addr_q.fields.offset, mode_q);
            hit   <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* src/data_mem.sv */
`default_nettype none

module data_mem (
    input  logic                                clk,
    input  logic                                re,
    input  logic                                we,
    input  cache_pkg::cache_addr_u              addr,
    input  logic [3:0]                          be,
    input  logic [cache_pkg::data_width-1:0]    wdata,
    output logic [cache_pkg::data_width-1:0]    rdata
);

    logic [cache_pkg::data_width-1:0]      mem [cache_pkg::mem_words];
    logic [cache_pkg::mem_index_width-1:0] index;

    // Word index, the byte offset is dropped
    assign index = addr.raw[cache_pkg::offset_width +: cache_pkg::mem_index_width];

    // Byte-enabled write
    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    mem[index][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // Read data holds until the next read
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[index];
        end
    end

endmodule

`default_nettype wire

/* src/l1_data_cache.sv */
`default_nettype none

module l1_data_cache (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                req,
    input  logic                                we,
    input  logic [2:0]                          mode,
    input  logic [cache_pkg::addr_width-1:0]    addr,
    input  logic [cache_pkg::data_width-1:0]    wdata,
    output logic [cache_pkg::data_width-1:0]    rdata,
    output logic                                rvalid,
    output logic                                hit,
    output logic                                busy
);

    cache_pkg::cache_addr_u             req_addr;
    cache_pkg::cache_addr_u             lookup_addr;

    logic                               hit0;
    logic                               hit1;
    logic                               valid0;
    logic                               valid1;
    logic [cache_pkg::data_width-1:0]   way0_data;
    logic [cache_pkg::data_width-1:0]   way1_data;

    logic                               fill0;
    logic                               fill1;
    logic                               store_en;
    logic [3:0]                         be;
    logic [cache_pkg::data_width-1:0]   store_data;

    logic                               mem_re;
    logic                               mem_we;
    logic [cache_pkg::data_width-1:0]   mem_rdata;

    assign req_addr.raw = addr;

    cache_way way0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .lookup_addr (lookup_addr),
        .fill        (fill0),
        .fill_data   (mem_rdata),
        .store       (store_en),
        .be          (be),
        .store_data  (store_data),
        .valid       (valid0),
        .hit         (hit0),
        .rdata       (way0_data)
    );

    cache_way way1 (
        .clk         (clk),
        .rst_n       (rst_n),
        .lookup_addr (lookup_addr),
        .fill        (fill1),
        .fill_data   (mem_rdata),
        .store       (store_en),
        .be          (be),
        .store_data  (store_data),
        .valid       (valid1),
        .hit         (hit1),
        .rdata       (way1_data)
    );

    cache_ctrl ctrl0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .we          (we),
        .mode        (mode),
        .addr        (req_addr),
        .wdata       (wdata),
        .hit0        (hit0),
        .hit1        (hit1),
        .way0_data   (way0_data),
        .way1_data   (way1_data),
        .valid0      (valid0),
        .valid1      (valid1),
        .mem_rdata   (mem_rdata),
        .lookup_addr (lookup_addr),
        .fill0       (fill0),
        .fill1       (fill1),
        .store_out   (store_en),
        .be          (be),
        .store_data  (store_data),
        .mem_re      (mem_re),
        .mem_we      (mem_we),
        .rdata       (rdata),
        .rvalid      (rvalid),
        .hit         (hit),
        .busy        (busy)
    );

    // Memory sees the same address as the ways
    data_mem mem0 (
        .clk   (clk),
        .re    (mem_re),
        .we    (mem_we),
        .addr  (lookup_addr),
        .be    (be),
        .wdata (store_data),
        .rdata (mem_rdata)
    );

endmodule

`default_nettype wire

/* verif/clk_gen.sv */
`default_nettype none

module clk_gen (
    output logic clk
);

    localparam int half_period = 2;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

endmodule

`default_nettype wire

/* verif/cache_checker.sv */
`default_nettype none

module cache_checker (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req,
    input  logic        we,
    input  logic [2:0]  mode,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    input  logic [31:0] rdata,
    input  logic        rvalid,
    input  logic        hit,
    input  logic        busy,
    input  int          test_id,
    input  logic        done,
    input  int          assert_fails,
    output int          error_count
);

    // Reference state: byte memory, two tag arrays, one LRU bit per set
    logic [7:0]  mem_bytes [4096];
    logic        valid_m [2][cache_pkg::num_sets];
    logic [25:0] tag_m [2][cache_pkg::num_sets];
    logic        lru_m [cache_pkg::num_sets];

    logic        pending = 1'b0;
    logic        finished = 1'b0;
    logic        exp_hit;
    logic        req_hit;
    logic [31:0] exp_data;
    int          age;
    int          set_i;
    int          cur_test = 0;
    int          tests = 0;
    int          checks = 0;
    int          errors = 0;
    int          test_checks = 0;
    int          test_errors = 0;
    int          reset_samples = 0;

    assign error_count = errors + assert_fails;

    function automatic logic [31:0] expected_load(input logic [11:0] a, input logic [2:0] m);
        logic [11:0] w;
        w = {a[11:2], 2'b00};
        case (m)
            cache_pkg::mode_b:  return {{24{mem_bytes[a][7]}}, mem_bytes[a]};
            cache_pkg::mode_bu: return {24'd0, mem_bytes[a]};
            cache_pkg::mode_h:  return {{16{mem_bytes[a + 1][7]}}, mem_bytes[a + 1], mem_bytes[a]};
            cache_pkg::mode_hu: return {16'd0, mem_bytes[a + 1], mem_bytes[a]};
            default: return {mem_bytes[w + 3], mem_bytes[w + 2], mem_bytes[w + 1], mem_bytes[w]};
        endcase
    endfunction

    // Little-endian byte placement
    task automatic write_bytes(input logic [11:0] a, input logic [2:0] m, input logic [31:0] d);
        case (m)
            cache_pkg::mode_b, cache_pkg::mode_bu: mem_bytes[a] = d[7:0];
            cache_pkg::mode_h, cache_pkg::mode_hu: begin
                mem_bytes[a]     = d[7:0];
                mem_bytes[a + 1] = d[15:8];
            end
            cache_pkg::mode_w: begin
                mem_bytes[a]     = d[7:0];
                mem_bytes[a + 1] = d[15:8];
                mem_bytes[a + 2] = d[23:16];
                mem_bytes[a + 3] = d[31:24];
            end
            default: ;
        endcase
    endtask

    // Tag lookup, refill of the victim on a load miss
    task automatic access_tags(input logic [31:0] a, input logic is_load, output logic was_hit);
        cache_pkg::cache_addr_u ua;
        logic [3:0]             s;
        logic                   victim;
        ua.raw  = a;
        s       = ua.fields.set;
        was_hit = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (valid_m[w][s] && (tag_m[w][s] == ua.fields.tag)) begin
                was_hit  = 1'b1;
                lru_m[s] = (w == 0);
            end
        end
        if (!was_hit && is_load) begin
            victim = !valid_m[0][s] ? 1'b0 : (!valid_m[1][s] ? 1'b1 : lru_m[s]);
            valid_m[victim][s] = 1'b1;
            tag_m[victim][s]   = ua.fields.tag;
            lru_m[s]           = !victim;
        end
    endtask

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks++;
        test_checks++;
        if (expected !== actual) begin
            $display("Error at %0t: %s expected %h, actual %h", $time, name, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic finish_test();
        tests++;
        $display("Test %0d %s: %0d checks, %0d errors", cur_test,
                 (test_errors == 0) ? "passed" : "failed", test_checks, test_errors);
    endtask

    always @(posedge clk) begin
        if (test_id != cur_test) begin
            if (cur_test != 0) begin
                finish_test();
            end
            cur_test    = test_id;
            test_checks = 0;
            test_errors = 0;
        end
        if (!rst_n) begin
            for (set_i = 0; set_i < cache_pkg::num_sets; set_i++) begin
                valid_m[0][set_i] = 1'b0;
                valid_m[1][set_i] = 1'b0;
                lru_m[set_i]      = 1'b0;
            end
            // First sample may still show the power-up value
            if (reset_samples > 0) begin
                compare("rvalid", 32'd0, {31'd0, rvalid});
                compare("busy", 32'd0, {31'd0, busy});
            end
            reset_samples++;
            pending = 1'b0;
        end else begin
            if (rvalid && !pending) begin
                $display("Test %0d: rvalid at %0t with no load outstanding", cur_test, $time);
                errors++;
                test_errors++;
            end else if (rvalid) begin
                compare("rdata", exp_data, rdata);
                compare("hit", {31'd0, exp_hit}, {31'd0, hit});
                pending = 1'b0;
            end else if (pending) begin
                age++;
                if (age >= 3) begin
                    $display("Test %0d: load at %0t got no rvalid", cur_test, $time);
                    errors++;
                    test_errors++;
                    pending = 1'b0;
                end
            end
            if (req && we) begin
                access_tags(addr, 1'b0, req_hit);
                write_bytes(addr[11:0], mode, wdata);
            end else if (req) begin
                access_tags(addr, 1'b1, req_hit);
                exp_hit  = req_hit;
                exp_data = expected_load(addr[11:0], mode);
                pending  = 1'b1;
                age      = 0;
            end
        end
        if (done && !finished) begin
            finish_test();
            $display("Totals: %0d tests, %0d checks, %0d checker errors, %0d assertion failures",
                     tests, checks, errors, assert_fails);
            finished = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* verif/cache_assert.sv */
`default_nettype none

module cache_assert (
    input logic clk,
    input logic rst_n,
    input logic req,
    input logic busy,
    input logic rvalid
);

    int fails = 0;

    // Requester must hold off during a refill
    no_req_in_busy: assert property (@(posedge clk) disable iff (!rst_n) busy |-> !req)
        else begin
            $error("req asserted while busy");
            fails++;
        end

    // Refill takes one cycle, then the result strobe
    busy_then_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
        busy |=> (!busy && rvalid))
        else begin
            $error("busy not followed by rvalid after one cycle");
            fails++;
        end

    rvalid_not_busy: assert property (@(posedge clk) disable iff (!rst_n) !(rvalid && busy))
        else begin
            $error("rvalid and busy high together");
            fails++;
        end

    quiet_in_reset: assert property (@(posedge clk) !rst_n |-> (!rvalid && !busy))
        else begin
            $error("rvalid or busy high during reset");
            fails++;
        end

endmodule

bind cache_ctrl cache_assert proto_check (
    .clk    (clk),
    .rst_n  (rst_n),
    .req    (req),
    .busy   (busy),
    .rvalid (rvalid)
);

`default_nettype wire

/* verif/cache_tb.sv */
`default_nettype none

module cache_tb;

    localparam int clk_period   = 4;
    localparam int reset_cycles = 16;
    localparam int seed         = 28655;
    localparam int op_load      = 0;
    localparam int op_store     = 1;
    localparam int op_reset     = 2;

    logic        clk;
    logic        rst_n;
    logic        req;
    logic        we;
    logic [2:0]  mode;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        rvalid;
    logic        hit;
    logic        busy;
    logic        done;
    logic        rows_ready = 1'b0;
    int          test_id;
    int          error_count;
    int          i;

    // Stimulus table with one row per request
    int          row_test [$];
    int          row_op [$];
    logic [2:0]  row_mode [$];
    logic [31:0] row_addr [$];
    logic [31:0] row_data [$];

    clk_gen clk0 (.clk(clk));

    l1_data_cache dut0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (req),
        .we     (we),
        .mode   (mode),
        .addr   (addr),
        .wdata  (wdata),
        .rdata  (rdata),
        .rvalid (rvalid),
        .hit    (hit),
        .busy   (busy)
    );

    cache_checker chk0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .we           (we),
        .mode         (mode),
        .addr         (addr),
        .wdata        (wdata),
        .rdata        (rdata),
        .rvalid       (rvalid),
        .hit          (hit),
        .busy         (busy),
        .test_id      (test_id),
        .done         (done),
        .assert_fails (dut0.ctrl0.proto_check.fails),
        .error_count  (error_count)
    );

    task automatic add_row(input int test, input int op, input logic [2:0] m,
                           input logic [31:0] a);
        row_test.push_back(test);
        row_op.push_back(op);
        row_mode.push_back(m);
        row_addr.push_back(a);
        row_data.push_back($urandom());
    endtask

    task automatic build_table();
        int o;
        int last;
        add_row(1, op_store, cache_pkg::mode_w, 32'h100);
        add_row(1, op_load, cache_pkg::mode_w, 32'h100);
        add_row(1, op_load, cache_pkg::mode_w, 32'h100);
        // Every legal offset for byte and halfword loads
        add_row(2, op_store, cache_pkg::mode_w, 32'h204);
        // Mixed sign bits so signed and unsigned loads differ
        last = row_data.size() - 1;
        row_data[last] = (row_data[last] & ~32'h8000_0080) | 32'h0080_8000;
        for (o = 0; o < 4; o++) begin
            add_row(2, op_load, cache_pkg::mode_b, 32'h204 + o);
            add_row(2, op_load, cache_pkg::mode_bu, 32'h204 + o);
        end
        for (o = 0; o < 4; o += 2) begin
            add_row(2, op_load, cache_pkg::mode_h, 32'h204 + o);
            add_row(2, op_load, cache_pkg::mode_hu, 32'h204 + o);
        end
        // Partial stores to a cached word and then to an uncached one
        add_row(3, op_store, cache_pkg::mode_w, 32'h308);
        add_row(3, op_load, cache_pkg::mode_w, 32'h308);
        add_row(3, op_store, cache_pkg::mode_b, 32'h309);
        add_row(3, op_store, cache_pkg::mode_h, 32'h30a);
        add_row(3, op_load, cache_pkg::mode_w, 32'h308);
        add_row(3, op_load, cache_pkg::mode_bu, 32'h309);
        add_row(3, op_store, cache_pkg::mode_w, 32'h30c);
        add_row(3, op_store, cache_pkg::mode_b, 32'h30f);
        add_row(3, op_store, cache_pkg::mode_h, 32'h30c);
        add_row(3, op_load, cache_pkg::mode_w, 32'h30c);
        add_row(3, op_load, cache_pkg::mode_h, 32'h30e);
        // Three tags in set 5 in the order A B A C A B C A
        add_row(4, op_store, cache_pkg::mode_w, 32'h414);
        add_row(4, op_store, cache_pkg::mode_w, 32'h814);
        add_row(4, op_store, cache_pkg::mode_w, 32'hc14);
        add_row(4, op_load, cache_pkg::mode_w, 32'h414);
        add_row(4, op_load, cache_pkg::mode_w, 32'h814);
        add_row(4, op_load, cache_pkg::mode_w, 32'h414);
        add_row(4, op_load, cache_pkg::mode_w, 32'hc14);
        add_row(4, op_load, cache_pkg::mode_w, 32'h414);
        add_row(4, op_load, cache_pkg::mode_w, 32'h814);
        add_row(4, op_load, cache_pkg::mode_w, 32'hc14);
        add_row(4, op_load, cache_pkg::mode_w, 32'h414);
        add_row(5, op_reset, cache_pkg::mode_w, 32'h0);
        add_row(5, op_load, cache_pkg::mode_w, 32'h100);
        add_row(5, op_load, cache_pkg::mode_w, 32'h414);
        add_row(5, op_load, cache_pkg::mode_hu, 32'h206);
    endtask

    // A hit answers within two edges and a refill within three
    task automatic wait_result();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!rvalid && n < 3);
    endtask

    initial begin
        req     <= 1'b0;
        we      <= 1'b0;
        mode    <= 3'd0;
        addr    <= 32'd0;
        wdata   <= 32'd0;
        rst_n   <= 1'b0;
        done    <= 1'b0;
        test_id <= 0;
        void'($urandom(seed));
        build_table();
        rows_ready = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        for (i = 0; i < row_op.size(); i++) begin
            test_id <= row_test[i];
            if (row_op[i] == op_reset) begin
                // Let a preceding store reach memory first
                @(posedge clk);
                rst_n <= 1'b0;
                repeat (2) @(posedge clk);
                rst_n <= 1'b1;
                @(posedge clk);
            end else begin
                req   <= 1'b1;
                we    <= (row_op[i] == op_store);
                mode  <= row_mode[i];
                addr  <= row_addr[i];
                wdata <= row_data[i];
                @(posedge clk);
                req <= 1'b0;
                if (row_op[i] == op_load) begin
                    wait_result();
                end
            end
        end
        repeat (2) @(posedge clk);
        done <= 1'b1;
        repeat (2) @(posedge clk);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        wait (rows_ready);
        #((reset_cycles + 4 * row_op.size() + 20) * clk_period);
        $display("Watchdog expired at %0t before the table was done", $time);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
src/cache_pkg.sv
src/cache_way.sv
src/cache_ctrl.sv
src/data_mem.sv
src/l1_data_cache.sv
verif/clk_gen.sv
verif/cache_checker.sv
verif/cache_assert.sv
verif/cache_tb.sv

/* Bender.yml */
package:
  name: l1_data_cache

sources:
  - src/cache_pkg.sv
  - src/cache_way.sv
  - src/cache_ctrl.sv
  - src/data_mem.sv
  - src/l1_data_cache.sv
  - target: test
    files:
      - verif/clk_gen.sv
      - verif/cache_checker.sv
      - verif/cache_assert.sv
      - verif/cache_tb.sv
